//--- source/core_consts.svh
// core widths and opcodes
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// datapath and instruction widths
`define XLEN        8
`define ILEN        16

// retirement trace record
`define TAG_W       6
`define CYC_W       16
`define STALL_W     4
`define TRACE_DEPTH 4

// data memory size in bytes
`define DMEM_WORDS  16

// opcodes
`define OP_ADD      4'd0
`define OP_SUB      4'd1
`define OP_XOR      4'd2
`define OP_ADDI     4'd3
`define OP_LD       4'd4
`define OP_ST       4'd5

`endif

//--- source/core_pkg.sv
// core types
`default_nettype none

`include "core_consts.svh"

package core_pkg;

    // one instruction word, two decodings
    // register view for ADD, SUB, XOR and the ST data source
    // immediate view for ADDI, LD and the ST offset
    typedef union packed {
        struct packed {
            logic [3:0] op;
            logic [1:0] rd;
            logic [1:0] rs1;
            logic [1:0] rs2;
            logic [5:0] spare;
        } r;
        struct packed {
            logic [3:0]       op;
            logic [1:0]       rd;
            logic [1:0]       rs1;
            logic [`XLEN-1:0] imm;
        } i;
    } instr_u;

endpackage

`default_nettype wire

//--- source/fetch_stage.sv
// instruction fetch register
`timescale 1ns/100ps
`default_nettype none

module fetch_stage (
    input  logic             clk,
    input  logic             rst,
    input  logic             instr_valid,
    input  core_pkg::instr_u instr_data,
    output logic             instr_ready,
    input  logic             stall_front,
    input  logic             hold_all,
    output logic             fd_valid,
    output core_pkg::instr_u fd_instr
);

    logic accept;

    // the front end takes a word whenever decode can move on
    assign instr_ready = !(stall_front || hold_all);
    assign accept      = instr_valid && instr_ready;

    // valid falls once decode has taken the word and nothing new arrived
    always_ff @(posedge clk) begin
        if (rst) begin
            fd_valid <= 1'b0;
        end else if (instr_ready) begin
            fd_valid <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            fd_instr <= instr_data;
        end
    end

endmodule

`default_nettype wire

//--- source/decode_stage.sv
// decode and register file
`timescale 1ns/100ps
`default_nettype none

`include "core_consts.svh"

module decode_stage (
    input  logic             clk,
    input  logic             rst,
    input  logic             fd_valid,
    input  core_pkg::instr_u fd_instr,
    input  logic             stall_front,
    input  logic             hold_all,
    input  logic             wb_valid,
    input  logic             wb_we,
    input  logic [1:0]       wb_rd,
    input  logic [`XLEN-1:0] wb_data,
    output logic             de_valid,
    output logic [3:0]       de_op,
    output logic [1:0]       de_rd,
    output logic [1:0]       de_rs1,
    output logic [1:0]       de_rs2,
    output logic [`XLEN-1:0] de_a,
    output logic [`XLEN-1:0] de_b,
    output logic [`XLEN-1:0] de_imm
);

    logic [`XLEN-1:0] regs [4];
    logic [`XLEN-1:0] rd_a;
    logic [`XLEN-1:0] rd_b;
    logic             wb_write;

    assign wb_write = wb_valid && wb_we;

    //////////////////////////////////////////////////////////////////////
    // register file
    //////////////////////////////////////////////////////////////////////

    // registers start at zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_write) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // write-through, a result retiring this cycle is seen at once
    assign rd_a = (wb_write && wb_rd == fd_instr.r.rs1) ? wb_data : regs[fd_instr.r.rs1];
    assign rd_b = (wb_write && wb_rd == fd_instr.r.rs2) ? wb_data : regs[fd_instr.r.rs2];

    //////////////////////////////////////////////////////////////////////
    // decode/execute register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            de_valid <= 1'b0;
        end else if (!hold_all && !stall_front) begin
            de_valid <= fd_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_all) begin
            if (!stall_front) begin
                de_op  <= fd_instr.r.op;
                de_rd  <= fd_instr.r.rd;
                de_rs1 <= fd_instr.r.rs1;
                de_rs2 <= fd_instr.r.rs2;
                de_imm <= fd_instr.i.imm;
                de_a   <= rd_a;
                de_b   <= rd_b;
            end else begin
                // a held instruction must not miss a result leaving write-back
                if (wb_write && wb_rd == de_rs1) begin
                    de_a <= wb_data;
                end
                if (wb_write && wb_rd == de_rs2) begin
                    de_b <= wb_data;
                end
            end
        end
    end

    // the stream only ever carries the six defined opcodes
    a_known_op: assert property (@(posedge clk) disable iff (rst)
        fd_valid |-> fd_instr.r.op <= `OP_ST);

endmodule

`default_nettype wire

//--- source/exec_mem_stage.sv
// execute, memory and write-back
`timescale 1ns/100ps
`default_nettype none

`include "core_consts.svh"

module exec_mem_stage (
    input  logic             clk,
    input  logic             rst,
    input  logic             hold_all,
    input  logic             stall_front,
    input  logic             de_valid,
    input  logic [3:0]       de_op,
    input  logic [1:0]       de_rd,
    input  logic [1:0]       de_rs1,
    input  logic [1:0]       de_rs2,
    input  logic [`XLEN-1:0] de_a,
    input  logic [`XLEN-1:0] de_b,
    input  logic [`XLEN-1:0] de_imm,
    output logic             em_valid,
    output logic             em_is_load,
    output logic [1:0]       em_rd,
    output logic             wb_valid,
    output logic             wb_we,
    output logic [1:0]       wb_rd,
    output logic [`XLEN-1:0] wb_data,
    output logic [`XLEN-1:0] wb_instr_result
);

    localparam int ADDR_W = $clog2(`DMEM_WORDS);

    logic             em_we;
    logic             em_is_store;
    logic [`XLEN-1:0] em_alu;
    logic [`XLEN-1:0] em_sdata;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_y;
    logic [ADDR_W-1:0] mem_addr;
    logic [`XLEN-1:0] dmem [`DMEM_WORDS];

    // newest result wins, a load in memory has no data yet
    function automatic logic [`XLEN-1:0] fwd(input logic [1:0] rs, input logic [`XLEN-1:0] val);
        if (em_valid && em_we && !em_is_load && em_rd == rs) begin
            return em_alu;
        end
        if (wb_valid && wb_we && wb_rd == rs) begin
            return wb_data;
        end
        return val;
    endfunction

    always_comb begin
        op_a = fwd(de_rs1, de_a);
        op_b = fwd(de_rs2, de_b);
    end

    // ADDI, LD and ST all add the immediate
    always_comb begin
        case (de_op)
            `OP_ADD: alu_y = op_a + op_b;
            `OP_SUB: alu_y = op_a - op_b;
            `OP_XOR: alu_y = op_a ^ op_b;
            default: alu_y = op_a + de_imm;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // execute/memory register
    //////////////////////////////////////////////////////////////////////

    // a load-use stall sends a bubble on while decode holds
    always_ff @(posedge clk) begin
        if (rst) begin
            em_valid <= 1'b0;
        end else if (!hold_all) begin
            em_valid <= de_valid && !stall_front;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_all) begin
            em_is_load  <= de_op == `OP_LD;
            em_is_store <= de_op == `OP_ST;
            em_we       <= de_op != `OP_ST;
            em_rd       <= de_rd;
            em_alu      <= alu_y;
            em_sdata    <= op_b;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // data memory and write-back register
    //////////////////////////////////////////////////////////////////////

    assign mem_addr = em_alu[ADDR_W-1:0];

    always_ff @(posedge clk) begin
        if (em_valid && em_is_store && !hold_all) begin
            dmem[mem_addr] <= em_sdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else if (!hold_all) begin
            wb_valid <= em_valid;
        end
    end

    // stores carry the stored byte here with the write enable low
    always_ff @(posedge clk) begin
        if (!hold_all) begin
            wb_we <= em_we;
            wb_rd <= em_rd;
            if (em_is_load) begin
                wb_data <= dmem[mem_addr];
            end else if (em_is_store) begin
                wb_data <= em_sdata;
            end else begin
                wb_data <= em_alu;
            end
        end
    end

    assign wb_instr_result = wb_data;

endmodule

`default_nettype wire

//--- source/hazard_unit.sv
// load-use and back-pressure control
`timescale 1ns/100ps
`default_nettype none

`include "core_consts.svh"

module hazard_unit (
    input  logic       de_valid,
    input  logic [1:0] de_rs1,
    input  logic [1:0] de_rs2,
    input  logic [3:0] de_op,
    input  logic       em_valid,
    input  logic       em_is_load,
    input  logic [1:0] em_rd,
    input  logic       wb_valid,
    input  logic       fifo_full,
    output logic       stall_front,
    output logic       hold_all
);

    logic uses_rs2;
    logic rs1_hit;
    logic rs2_hit;

    // rs2 bits are part of the immediate for ADDI and LD
    assign uses_rs2 = de_op == `OP_ADD || de_op == `OP_SUB ||
                      de_op == `OP_XOR || de_op == `OP_ST;

    assign rs1_hit = de_rs1 == em_rd;
    assign rs2_hit = uses_rs2 && de_rs2 == em_rd;

    // loaded byte reaches execute one cycle late through the write-back path
    assign stall_front = de_valid && em_valid && em_is_load && (rs1_hit || rs2_hit);

    // a record with nowhere to go freezes everything
    assign hold_all = fifo_full && wb_valid;

endmodule

`default_nettype wire

//--- source/retire_trace.sv
// retirement trace unit
`timescale 1ns/100ps
`default_nettype none

`include "core_consts.svh"

module retire_trace (
    input  logic                clk,
    input  logic                rst,
    input  logic                instr_valid,
    input  logic                instr_ready,
    input  core_pkg::instr_u    instr_data,
    input  logic                fd_valid,
    input  logic                de_valid,
    input  logic                em_valid,
    input  logic                wb_valid,
    input  logic                stall_front,
    input  logic                hold_all,
    input  logic [`XLEN-1:0]    wb_instr_result,
    output logic                fifo_full,
    output logic                trace_valid,
    output logic [`TAG_W-1:0]   trace_tag,
    output logic [`ILEN-1:0]    trace_instr,
    output logic [`XLEN-1:0]    trace_result,
    output logic [`CYC_W-1:0]   trace_fetch_cycle,
    output logic [`CYC_W-1:0]   trace_retire_cycle,
    output logic [`STALL_W-1:0] trace_stall_cycles,
    input  logic                trace_ready
);

    localparam int TAGS  = 1 << `TAG_W;
    localparam int PTR_W = $clog2(`TRACE_DEPTH);
    localparam int REC_W = `TAG_W + `ILEN + `XLEN + 2 * `CYC_W + `STALL_W;

    logic [`CYC_W-1:0]   cyc;
    logic [`TAG_W-1:0]   next_tag;
    logic [`TAG_W-1:0]   exp_tag;
    logic [`TAG_W-1:0]   stage_tag [4];
    logic [3:0]          stage_held;
    logic [`CYC_W-1:0]   fetch_tbl [TAGS];
    logic [`ILEN-1:0]    instr_tbl [TAGS];
    logic [`STALL_W-1:0] stall_tbl [TAGS];
    logic [REC_W-1:0]    fifo_mem [`TRACE_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [PTR_W:0]      count;
    logic                accept;
    logic                advance;
    logic                push;
    logic                pop;

    assign accept  = instr_valid && instr_ready;
    assign advance = !(stall_front || hold_all);
    assign push    = wb_valid && !hold_all;
    assign pop     = trace_valid && trace_ready;

    // held stages: fetch/decode on any stall, the back end only on hold_all
    assign stage_held[0] = fd_valid && !advance;
    assign stage_held[1] = de_valid && !advance;
    assign stage_held[2] = em_valid && hold_all;
    assign stage_held[3] = wb_valid && hold_all;

    //////////////////////////////////////////////////////////////////////
    // cycle counter and tags
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            cyc      <= '0;
            next_tag <= '0;
            exp_tag  <= '0;
        end else begin
            cyc <= cyc + 1'b1;
            if (accept) begin
                next_tag <= next_tag + 1'b1;
            end
            if (push) begin
                exp_tag <= exp_tag + 1'b1;
            end
        end
    end

    // tags move exactly like the stage registers
    always_ff @(posedge clk) begin
        if (advance) begin
            stage_tag[0] <= next_tag;
            stage_tag[1] <= stage_tag[0];
        end
        if (!hold_all) begin
            stage_tag[2] <= stage_tag[1];
            stage_tag[3] <= stage_tag[2];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // per-tag tables
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (accept) begin
            fetch_tbl[next_tag] <= cyc;
            instr_tbl[next_tag] <= instr_data;
        end
    end

    // stall count saturates; a fresh tag is never one still in flight
    always_ff @(posedge clk) begin
        for (int s = 0; s < 4; s++) begin
            if (stage_held[s] && stall_tbl[stage_tag[s]] != '1) begin
                stall_tbl[stage_tag[s]] <= stall_tbl[stage_tag[s]] + 1'b1;
            end
        end
        if (accept) begin
            stall_tbl[next_tag] <= '0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // trace FIFO
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= {stage_tag[3], instr_tbl[stage_tag[3]], wb_instr_result,
                                 fetch_tbl[stage_tag[3]], cyc, stall_tbl[stage_tag[3]]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign fifo_full   = count == `TRACE_DEPTH;
    assign trace_valid = count != '0;
    assign {trace_tag, trace_instr, trace_result, trace_fetch_cycle,
            trace_retire_cycle, trace_stall_cycles} = fifo_mem[rd_ptr];

    // hold_all from the hazard unit must stop write-back before overflow
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        push |-> count < `TRACE_DEPTH);

    // records leave in fetch order
    a_in_order: assert property (@(posedge clk) disable iff (rst)
        push |-> stage_tag[3] == exp_tag);

endmodule

`default_nettype wire

//--- source/pipe_top.sv
// five-stage pipeline top
`timescale 1ns/100ps
`default_nettype none

`include "core_consts.svh"

module pipe_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                instr_valid,
    input  core_pkg::instr_u    instr_data,
    output logic                instr_ready,
    output logic                trace_valid,
    output logic [`TAG_W-1:0]   trace_tag,
    output logic [`ILEN-1:0]    trace_instr,
    output logic [`XLEN-1:0]    trace_result,
    output logic [`CYC_W-1:0]   trace_fetch_cycle,
    output logic [`CYC_W-1:0]   trace_retire_cycle,
    output logic [`STALL_W-1:0] trace_stall_cycles,
    input  logic                trace_ready
);

    import core_pkg::*;

    // fetch/decode
    logic             fd_valid;
    instr_u           fd_instr;

    // decode/execute
    logic             de_valid;
    logic [3:0]       de_op;
    logic [1:0]       de_rd;
    logic [1:0]       de_rs1;
    logic [1:0]       de_rs2;
    logic [`XLEN-1:0] de_a;
    logic [`XLEN-1:0] de_b;
    logic [`XLEN-1:0] de_imm;

    // memory and write-back
    logic             em_valid;
    logic             em_is_load;
    logic [1:0]       em_rd;
    logic             wb_valid;
    logic             wb_we;
    logic [1:0]       wb_rd;
    logic [`XLEN-1:0] wb_data;
    logic [`XLEN-1:0] wb_instr_result;

    // control
    logic             stall_front;
    logic             hold_all;
    logic             fifo_full;

    fetch_stage    u_fetch (.*);
    decode_stage   u_decode (.*);
    exec_mem_stage u_exec_mem (.*);
    hazard_unit    u_hazard (.*);
    retire_trace   u_trace (.*);

endmodule

`default_nettype wire

//--- verif/clk_gen.sv
// testbench clock and reset
`timescale 1ns/100ps
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // released on a falling edge, clear of the sampling edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- verif/pipe_tb.sv
// pipeline testbench
`timescale 1ns/100ps
`default_nettype none

`include "core_consts.svh"

module pipe_tb;

    localparam int ROWS  = 20;
    localparam int LIMIT = 10 * ROWS + 100;

    logic                clk;
    logic                rst;
    logic                instr_valid;
    logic [`ILEN-1:0]    instr_data;
    logic                instr_ready;
    logic                trace_valid;
    logic [`TAG_W-1:0]   trace_tag;
    logic [`ILEN-1:0]    trace_instr;
    logic [`XLEN-1:0]    trace_result;
    logic [`CYC_W-1:0]   trace_fetch_cycle;
    logic [`CYC_W-1:0]   trace_retire_cycle;
    logic [`STALL_W-1:0] trace_stall_cycles;
    logic                trace_ready;

    // stimulus table and expected values
    logic [`ILEN-1:0] word_tbl   [ROWS];
    int               gap_tbl    [ROWS];
    string            name_tbl   [ROWS];
    logic [`XLEN-1:0] result_tbl [ROWS];
    logic             load_use   [ROWS];

    // reference machine state
    logic [`XLEN-1:0] model_regs [4];
    logic [`XLEN-1:0] model_mem  [`DMEM_WORDS];

    int     rec_count = 0;
    int     cycles    = 0;
    integer seed      = 32'h5fb9dbf4;

    clk_gen u_clk_gen (
        .clk(clk),
        .rst(rst)
    );

    pipe_top UUT (
        .clk(clk),
        .rst(rst),
        .instr_valid(instr_valid),
        .instr_data(instr_data),
        .instr_ready(instr_ready),
        .trace_valid(trace_valid),
        .trace_tag(trace_tag),
        .trace_instr(trace_instr),
        .trace_result(trace_result),
        .trace_fetch_cycle(trace_fetch_cycle),
        .trace_retire_cycle(trace_retire_cycle),
        .trace_stall_cycles(trace_stall_cycles),
        .trace_ready(trace_ready)
    );

    //////////////////////////////////////////////////////////////////////
    // instruction encoding and the reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [`ILEN-1:0] reg_word(input logic [3:0] op, input logic [1:0] rd,
                                                   input logic [1:0] rs1, input logic [1:0] rs2);
        return {op, rd, rs1, rs2, 6'b0};
    endfunction

    function automatic logic [`ILEN-1:0] imm_word(input logic [3:0] op, input logic [1:0] rd,
                                                   input logic [1:0] rs1, input logic [7:0] imm);
        return {op, rd, rs1, imm};
    endfunction

    // the data register doubles as the top two offset bits
    function automatic logic [`ILEN-1:0] store_word(input logic [1:0] rs1, input logic [1:0] rs2,
                                                     input logic [5:0] off);
        return {`OP_ST, 2'b00, rs1, rs2, off};
    endfunction

    function automatic logic reads_reg(input logic [`ILEN-1:0] w, input logic [1:0] r);
        logic uses_rs2;
        uses_rs2 = w[15:12] == `OP_ADD || w[15:12] == `OP_SUB ||
                   w[15:12] == `OP_XOR || w[15:12] == `OP_ST;
        return w[9:8] == r || (uses_rs2 && w[7:6] == r);
    endfunction

    task add_row(input int idx, input string name, input int gap, input logic [`ILEN-1:0] w);
        name_tbl[idx] = name;
        gap_tbl[idx]  = gap;
        word_tbl[idx] = w;
    endtask

    task load_table;
        add_row(0,  "addi_r1",     0, imm_word(`OP_ADDI, 2'd1, 2'd0, 8'h05));
        add_row(1,  "addi_r2",     0, imm_word(`OP_ADDI, 2'd2, 2'd0, 8'h03));
        add_row(2,  "add_fwd",     0, reg_word(`OP_ADD, 2'd3, 2'd1, 2'd2));
        add_row(3,  "sub_fwd",     0, reg_word(`OP_SUB, 2'd0, 2'd3, 2'd1));
        add_row(4,  "xor_fwd",     0, reg_word(`OP_XOR, 2'd1, 2'd0, 2'd3));
        add_row(5,  "addi_wrap",   0, imm_word(`OP_ADDI, 2'd2, 2'd2, 8'hfe));
        add_row(6,  "st_a5",       0, store_word(2'd2, 2'd3, 6'h04));
        add_row(7,  "addi_gap",    2, imm_word(`OP_ADDI, 2'd0, 2'd0, 8'h10));
        add_row(8,  "ld_a5",       0, imm_word(`OP_LD, 2'd2, 2'd1, 8'hfa));
        add_row(9,  "ld_use_add",  0, reg_word(`OP_ADD, 2'd3, 2'd2, 2'd2));
        add_row(10, "st_a3",       0, store_word(2'd0, 2'd3, 6'h00));
        add_row(11, "ld_a3",       0, imm_word(`OP_LD, 2'd1, 2'd0, 8'hf0));
        add_row(12, "ld_use_addi", 0, imm_word(`OP_ADDI, 2'd1, 2'd1, 8'h01));
        add_row(13, "ld_a5_again", 1, imm_word(`OP_LD, 2'd0, 2'd2, 8'hfd));
        add_row(14, "ld_use_st",   0, store_word(2'd3, 2'd0, 6'h01));
        add_row(15, "ld_a1",       1, imm_word(`OP_LD, 2'd3, 2'd3, 8'h01));
        add_row(16, "ld_use_sub",  0, reg_word(`OP_SUB, 2'd2, 2'd1, 2'd3));
        add_row(17, "xor_back",    0, reg_word(`OP_XOR, 2'd0, 2'd2, 2'd1));
        add_row(18, "sub_back",    0, reg_word(`OP_SUB, 2'd1, 2'd0, 2'd1));
        add_row(19, "add_back",    3, reg_word(`OP_ADD, 2'd2, 2'd1, 2'd0));
    endtask

    // instruction-set rules applied in program order
    task run_model;
        logic [3:0]       op;
        logic [1:0]       rd;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] imm;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] res;
        for (int r = 0; r < 4; r++) begin
            model_regs[r] = '0;
        end
        for (int i = 0; i < ROWS; i++) begin
            op   = word_tbl[i][15:12];
            rd   = word_tbl[i][11:10];
            a    = model_regs[word_tbl[i][9:8]];
            b    = model_regs[word_tbl[i][7:6]];
            imm  = word_tbl[i][7:0];
            addr = a + imm;
            case (op)
                `OP_ADD:  res = a + b;
                `OP_SUB:  res = a - b;
                `OP_XOR:  res = a ^ b;
                `OP_ADDI: res = a + imm;
                `OP_LD:   res = model_mem[addr[3:0]];
                default: begin
                    model_mem[addr[3:0]] = b;
                    res = b;
                end
            endcase
            if (op != `OP_ST) begin
                model_regs[rd] = res;
            end
            result_tbl[i] = res;
            load_use[i]   = 1'b0;
            if (i > 0 && gap_tbl[i] == 0 && word_tbl[i-1][15:12] == `OP_LD) begin
                load_use[i] = reads_reg(word_tbl[i], word_tbl[i-1][11:10]);
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // checking
    //////////////////////////////////////////////////////////////////////

    task stop_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task check_value(input string name, input string what, input logic [31:0] expected,
                     input logic [31:0] actual);
        if (actual !== expected) begin
            stop_run($sformatf("mismatch %s %s: expected %0h, actual %0h",
                               name, what, expected, actual));
        end
    endtask

    // record on the port now transfers at the next rising edge
    task check_record;
        string             name;
        logic [`CYC_W-1:0] span;
        if (rec_count >= ROWS) begin
            stop_run("a trace record arrived after every instruction had already retired");
        end else begin
            name = name_tbl[rec_count];
            span = trace_retire_cycle - trace_fetch_cycle;
            check_value(name, "tag", rec_count % (1 << `TAG_W), trace_tag);
            check_value(name, "instr", word_tbl[rec_count], trace_instr);
            check_value(name, "result", result_tbl[rec_count], trace_result);
            if (trace_stall_cycles == '1) begin
                if (span < 4 + (1 << `STALL_W) - 1) begin
                    stop_run($sformatf("%s shows a saturated stall count but was in flight %0d cycles",
                                       name, span));
                end
            end else begin
                check_value(name, "retire minus fetch", 4 + trace_stall_cycles, span);
            end
            if (load_use[rec_count] && trace_stall_cycles == 0) begin
                stop_run($sformatf("%s depends on the load just before it but shows no stall",
                                   name));
            end
            rec_count++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus, trace sink and timeout
    //////////////////////////////////////////////////////////////////////

    task send_word(input logic [`ILEN-1:0] word);
        logic taken;
        instr_valid = 1'b1;
        instr_data  = word;
        taken       = 1'b0;
        while (!taken) begin
            // ready is settled here and holds up to the rising edge
            taken = instr_ready;
            @(negedge clk);
        end
        instr_valid = 1'b0;
    endtask

    initial begin
        instr_valid = 1'b0;
        instr_data  = '0;
        load_table();
        run_model();
        @(negedge rst);
        @(negedge clk);
        check_value("reset", "instr_ready", 1, instr_ready);
        check_value("reset", "trace_valid", 0, trace_valid);
        for (int i = 0; i < ROWS; i++) begin
            repeat (gap_tbl[i]) @(negedge clk);
            send_word(word_tbl[i]);
        end
        while (rec_count < ROWS) @(posedge clk);
        // a few more cycles to catch a stray record
        repeat (4) @(posedge clk);
        $display("TEST PASS");
        $finish;
    end

    // trace sink with random back-pressure
    initial begin
        trace_ready = 1'b0;
        @(negedge rst);
        forever begin
            @(negedge clk);
            trace_ready = ($random(seed) & 32'h3) != 0;
            if (trace_valid && trace_ready) begin
                check_record();
            end
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= LIMIT) begin
                stop_run($sformatf("timeout: only %0d of %0d trace records arrived in %0d cycles",
                                   rec_count, ROWS, LIMIT));
            end
        end
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+source
source/core_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/exec_mem_stage.sv
source/hazard_unit.sv
source/retire_trace.sv
source/pipe_top.sv
verif/clk_gen.sv
verif/pipe_tb.sv

//--- Bender.yml
package:
  name: pipe_trace

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/core_pkg.sv
      - source/fetch_stage.sv
      - source/decode_stage.sv
      - source/exec_mem_stage.sv
      - source/hazard_unit.sv
      - source/retire_trace.sv
      - source/pipe_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/clk_gen.sv
      - verif/pipe_tb.sv
